// File: hw/bus_pkg.sv
// Bus package with the address, data and timer widths and the APB and I/O response codes
`default_nettype none

package bus_pkg;

   // ----------------------------------------------------------------------
   // Widths
   // ----------------------------------------------------------------------
   localparam int ADDR_W     = 32;             // Byte address
   localparam int DATA_W     = 32;             // One bus word
   localparam int TIME_W     = 2 * DATA_W;     // mtime and mtimecmp span two words
   localparam int WORD_BYTES = DATA_W / 8;     // Bytes per word, used for alignment

   typedef logic [ADDR_W-1:0] addr_t;          // Address on APB and external I/O
   typedef logic [DATA_W-1:0] data_t;          // Read and write data
   typedef logic [TIME_W-1:0] time_t;          // Machine timer values

   // ----------------------------------------------------------------------
   // Response codes
   // ----------------------------------------------------------------------
   // pslverr values seen by the core side
   localparam logic RESP_OKAY  = 1'b0;         // Transfer completed normally
   localparam logic RESP_ERROR = 1'b1;         // Unmapped address or I/O fault

   // io_ack_fault values from the external device
   localparam logic IO_ACK_OK    = 1'b0;       // Device accepted the access
   localparam logic IO_ACK_FAULT = 1'b1;       // Device rejected it

endpackage : bus_pkg

`default_nettype wire

// File: hw/mmr_map_pkg.sv
// Memory map package for the interrupt block with base addresses, offsets and reset values
`default_nettype none

package mmr_map_pkg;

   import bus_pkg::*;

   // ----------------------------------------------------------------------
   // Default address map
   // ----------------------------------------------------------------------
   localparam addr_t INT_IO_BASE = 32'hFFFF_0000;   // Internal register window
   localparam addr_t INT_IO_SPAN = 32'h0000_0018;   // Bytes decoded inside the window

   // Inclusive external I/O range
   localparam addr_t EXT_IO_LO = 32'h8000_0000;
   localparam addr_t EXT_IO_HI = 32'h8000_FFFF;

   // ----------------------------------------------------------------------
   // Register offsets from INT_IO_BASE
   // ----------------------------------------------------------------------
   localparam addr_t MSIP_OFS        = 32'h0000_0000;   // Software interrupt pending
   localparam addr_t MTIMECMP_LO_OFS = 32'h0000_0008;   // Compare value, low word
   localparam addr_t MTIMECMP_HI_OFS = 32'h0000_000C;   // Compare value, high word
   localparam addr_t MTIME_LO_OFS    = 32'h0000_0010;   // Free running timer, low word
   localparam addr_t MTIME_HI_OFS    = 32'h0000_0014;   // Free running timer, high word

   // Compare starts at the top so the timer interrupt stays quiet after reset
   localparam time_t MTIMECMP_RESET = '1;

   // Internal register targets
   typedef enum logic [2:0]
   {
      SEL_NONE,           // Address does not hit a register
      SEL_MSIP,
      SEL_MTIMECMP_LO,
      SEL_MTIMECMP_HI,
      SEL_MTIME_LO,
      SEL_MTIME_HI
   } mmr_sel_e;

endpackage : mmr_map_pkg

`default_nettype wire

// File: hw/mmr_decoder.sv
// APB slave that decodes the map, strobes the timer registers and forwards external I/O
`default_nettype none

module mmr_decoder
#(
   parameter bus_pkg::addr_t INT_IO_BASE = mmr_map_pkg::INT_IO_BASE,
   parameter bus_pkg::addr_t EXT_IO_LO   = mmr_map_pkg::EXT_IO_LO,
   parameter bus_pkg::addr_t EXT_IO_HI   = mmr_map_pkg::EXT_IO_HI
)
(
   input  logic                  clk_in,
   input  logic                  rst,

   // APB slave side
   input  bus_pkg::addr_t        paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  bus_pkg::data_t        pwdata,
   output bus_pkg::data_t        prdata,
   output logic                  pready,
   output logic                  pslverr,

   // External I/O master side
   output logic                  io_req,
   output bus_pkg::addr_t        io_addr,
   output logic                  io_rd,
   output logic                  io_wr,
   output bus_pkg::data_t        io_wr_data,
   input  logic                  io_ack,
   input  logic                  io_ack_fault,
   input  bus_pkg::data_t        io_ack_data,

   // Register file in the interrupt unit
   input  bus_pkg::time_t        mtime,
   input  bus_pkg::time_t        mtimecmp,
   input  logic                  msip,
   output mmr_map_pkg::mmr_sel_e wr_sel,
   output logic                  wr_en,
   output bus_pkg::data_t        wr_data
);

   import bus_pkg::*;
   import mmr_map_pkg::*;

   logic     apb_setup;       // First cycle of a transfer
   logic     apb_access;      // Access phase, lasts until pready
   addr_t    int_ofs;         // Offset into the internal window
   mmr_sel_e int_sel;         // Register hit by paddr
   logic     int_hit;
   logic     ext_hit;
   logic     unmapped;
   data_t    int_rdata;       // Selected register word
   logic     io_busy;         // External request outstanding
   logic     io_wr_q;         // Direction of the outstanding request
   logic     ext_done;        // Device acknowledge ends the access

   assign apb_setup  = psel & ~penable;
   assign apb_access = psel & penable;

   // ----------------------------------------------------------------------
   // Address classification
   // ----------------------------------------------------------------------
   assign int_ofs = paddr - INT_IO_BASE;      // Wraps high below the base, so no hit

   always_comb
   begin
      case (int_ofs)
         MSIP_OFS:        int_sel = SEL_MSIP;
         MTIMECMP_LO_OFS: int_sel = SEL_MTIMECMP_LO;
         MTIMECMP_HI_OFS: int_sel = SEL_MTIMECMP_HI;
         MTIME_LO_OFS:    int_sel = SEL_MTIME_LO;
         MTIME_HI_OFS:    int_sel = SEL_MTIME_HI;
         default:         int_sel = SEL_NONE;   // Holes and unaligned offsets
      endcase
   end

   assign int_hit  = (int_sel != SEL_NONE);
   assign ext_hit  = (paddr >= EXT_IO_LO) && (paddr <= EXT_IO_HI);
   assign unmapped = ~int_hit & ~ext_hit;

   // Write strobe lands on the edge that closes the access phase
   assign wr_sel  = int_sel;
   assign wr_en   = apb_access & pwrite & int_hit;
   assign wr_data = pwdata;

   // Read mux over the register file
   always_comb
   begin
      case (int_sel)
         SEL_MSIP:        int_rdata = {{(DATA_W-1){1'b0}}, msip};
         SEL_MTIMECMP_LO: int_rdata = mtimecmp[DATA_W-1:0];
         SEL_MTIMECMP_HI: int_rdata = mtimecmp[2*DATA_W-1:DATA_W];
         SEL_MTIME_LO:    int_rdata = mtime[DATA_W-1:0];
         SEL_MTIME_HI:    int_rdata = mtime[2*DATA_W-1:DATA_W];
         default:         int_rdata = '0;
      endcase
   end

   // ----------------------------------------------------------------------
   // External request hold
   // ----------------------------------------------------------------------
   // Armed at the end of setup so io_req is high in the first access cycle
   always_ff @(posedge clk_in)
   begin
      if (rst)
         io_busy <= 1'b0;
      else if (io_busy)
      begin
         if (io_ack)
            io_busy <= 1'b0;                    // Drops the cycle after acknowledge
      end
      else if (apb_setup && ext_hit)
         io_busy <= 1'b1;
   end

   // Request payload, captured once and held until acknowledge
   always_ff @(posedge clk_in)
   begin
      if (!io_busy && apb_setup && ext_hit)
      begin
         io_addr    <= paddr;
         io_wr_q    <= pwrite;
         io_wr_data <= pwdata;
      end
   end

   assign io_req = io_busy;
   assign io_rd  = io_busy & ~io_wr_q;
   assign io_wr  = io_busy &  io_wr_q;

   assign ext_done = apb_access & io_busy & io_ack;

   // ----------------------------------------------------------------------
   // APB response
   // ----------------------------------------------------------------------
   // Internal and unmapped complete with zero wait states
   assign pready = (apb_access & (int_hit | unmapped)) | ext_done;

   always_comb
   begin
      if (ext_done)
         pslverr = (io_ack_fault == IO_ACK_FAULT) ? RESP_ERROR : RESP_OKAY;
      else if (apb_access && unmapped)
         pslverr = RESP_ERROR;
      else
         pslverr = RESP_OKAY;
   end

   always_comb
   begin
      if (int_hit)
         prdata = int_rdata;
      else if (ext_hit)
         prdata = io_ack_data;                  // Valid with pready on acknowledge
      else
         prdata = '0;                           // Unmapped reads return zero
   end

endmodule : mmr_decoder

`default_nettype wire

// File: hw/interrupt_unit.sv
// Machine timer, software interrupt registers and the wait-for-interrupt halt control
`default_nettype none

module interrupt_unit
(
   input  logic                  clk_in,
   input  logic                  rst,

   // Register writes from the decoder
   input  mmr_map_pkg::mmr_sel_e wr_sel,
   input  logic                  wr_en,
   input  bus_pkg::data_t        wr_data,

   input  logic                  ext_irq,     // External interrupt line
   input  logic                  wfi,         // Core asks to sleep

   // Register contents for readback
   output bus_pkg::time_t        mtime,
   output bus_pkg::time_t        mtimecmp,
   output logic                  msip,

   output logic                  timer_irq,
   output logic                  sw_irq,
   output logic                  cpu_halt
);

   import bus_pkg::*;
   import mmr_map_pkg::*;

   logic wake;                                 // Any interrupt pending

   // ----------------------------------------------------------------------
   // mtime
   // ----------------------------------------------------------------------
   // Counts every clock, a write to one half freezes the other half for that cycle
   always_ff @(posedge clk_in)
   begin
      if (rst)
         mtime <= '0;
      else if (wr_en && (wr_sel == SEL_MTIME_LO))
         mtime[DATA_W-1:0] <= wr_data;
      else if (wr_en && (wr_sel == SEL_MTIME_HI))
         mtime[TIME_W-1:DATA_W] <= wr_data;
      else
         mtime <= mtime + 1'b1;
   end

   // ----------------------------------------------------------------------
   // mtimecmp and msip
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (rst)
         mtimecmp <= MTIMECMP_RESET;
      else if (wr_en)
      begin
         if (wr_sel == SEL_MTIMECMP_LO)
            mtimecmp[DATA_W-1:0] <= wr_data;
         else if (wr_sel == SEL_MTIMECMP_HI)
            mtimecmp[TIME_W-1:DATA_W] <= wr_data;
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (rst)
         msip <= 1'b0;
      else if (wr_en && (wr_sel == SEL_MSIP))
         msip <= wr_data[0];                    // Only bit 0 is implemented
   end

   // Compare straight off the registers so a write shows up at once
   assign timer_irq = (mtime >= mtimecmp);
   assign sw_irq    = msip;

   // ----------------------------------------------------------------------
   // Halt control
   // ----------------------------------------------------------------------
   assign wake = ext_irq | timer_irq | sw_irq;

   // Sleep on wfi, wake on any interrupt, wake wins when both are seen
   always_ff @(posedge clk_in)
   begin
      if (rst)
         cpu_halt <= 1'b0;
      else if (wake)
         cpu_halt <= 1'b0;
      else if (wfi)
         cpu_halt <= 1'b1;
   end

endmodule : interrupt_unit

`default_nettype wire

// File: hw/riscy_irq_top.sv
// Top level of the interrupt and I/O block joining the decoder and the interrupt unit
`default_nettype none

module riscy_irq_top
#(
   parameter bus_pkg::addr_t INT_IO_BASE = mmr_map_pkg::INT_IO_BASE,
   parameter bus_pkg::addr_t EXT_IO_LO   = mmr_map_pkg::EXT_IO_LO,
   parameter bus_pkg::addr_t EXT_IO_HI   = mmr_map_pkg::EXT_IO_HI
)
(
   input  logic           clk_in,
   input  logic           rst,

   // APB slave from the core load and store path
   input  bus_pkg::addr_t paddr,
   input  logic           psel,
   input  logic           penable,
   input  logic           pwrite,
   input  bus_pkg::data_t pwdata,
   output bus_pkg::data_t prdata,
   output logic           pready,
   output logic           pslverr,

   // External I/O bus
   output logic           io_req,
   output bus_pkg::addr_t io_addr,
   output logic           io_rd,
   output logic           io_wr,
   output bus_pkg::data_t io_wr_data,
   input  logic           io_ack,
   input  logic           io_ack_fault,
   input  bus_pkg::data_t io_ack_data,

   // Interrupts and sleep
   input  logic           ext_irq,
   input  logic           wfi,
   output logic           timer_irq,
   output logic           sw_irq,
   output logic           cpu_halt
);

   import bus_pkg::*;
   import mmr_map_pkg::*;

   localparam addr_t INT_IO_LAST = INT_IO_BASE + INT_IO_SPAN - 1;   // Last byte of the window

   mmr_sel_e wr_sel;
   logic     wr_en;
   data_t    wr_data;
   time_t    mtime;
   time_t    mtimecmp;
   logic     msip;

   // ----------------------------------------------------------------------
   // Address map checks at elaboration
   // ----------------------------------------------------------------------
   if ((INT_IO_BASE % WORD_BYTES) != 0)
      $fatal(1, "INT_IO_BASE must be word aligned");
   if ((EXT_IO_LO % WORD_BYTES) != 0)
      $fatal(1, "EXT_IO_LO must be word aligned");
   if ((EXT_IO_HI % WORD_BYTES) != (WORD_BYTES - 1))
      $fatal(1, "EXT_IO_HI must be the last byte of a word");
   if (EXT_IO_HI < EXT_IO_LO)
      $fatal(1, "EXT_IO_HI must not be below EXT_IO_LO");
   if (INT_IO_LAST < INT_IO_BASE)
      $fatal(1, "Internal window wraps past the top of the address space");
   if (!((INT_IO_LAST < EXT_IO_LO) || (INT_IO_BASE > EXT_IO_HI)))
      $fatal(1, "Internal window overlaps the external I/O range");

   mmr_decoder
   #(
      .INT_IO_BASE (INT_IO_BASE),
      .EXT_IO_LO   (EXT_IO_LO),
      .EXT_IO_HI   (EXT_IO_HI)
   )
   i_mmr_decoder
   (
      .clk_in       (clk_in),
      .rst          (rst),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .io_req       (io_req),
      .io_addr      (io_addr),
      .io_rd        (io_rd),
      .io_wr        (io_wr),
      .io_wr_data   (io_wr_data),
      .io_ack       (io_ack),
      .io_ack_fault (io_ack_fault),
      .io_ack_data  (io_ack_data),
      .mtime        (mtime),
      .mtimecmp     (mtimecmp),
      .msip         (msip),
      .wr_sel       (wr_sel),
      .wr_en        (wr_en),
      .wr_data      (wr_data)
   );

   interrupt_unit i_interrupt_unit
   (
      .clk_in    (clk_in),
      .rst       (rst),
      .wr_sel    (wr_sel),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .ext_irq   (ext_irq),
      .wfi       (wfi),
      .mtime     (mtime),
      .mtimecmp  (mtimecmp),
      .msip      (msip),
      .timer_irq (timer_irq),
      .sw_irq    (sw_irq),
      .cpu_halt  (cpu_halt)
   );

endmodule : riscy_irq_top

`default_nettype wire

// File: dv/riscy_irq_checker.sv
// Concurrent assertions on APB handshake, external I/O hold and interrupt wake of the top level
`default_nettype none

module riscy_irq_checker
(
   input  logic                  clk_in,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pready,
   input  logic                  io_req,
   input  logic                  io_ack,
   input  bus_pkg::addr_t        io_addr,
   input  logic                  io_rd,
   input  logic                  io_wr,
   input  bus_pkg::data_t        io_wr_data,
   input  logic                  wr_en,      // Register write strobe inside the top
   input  mmr_map_pkg::mmr_sel_e wr_sel,
   input  bus_pkg::data_t        wr_data,
   input  logic                  ext_irq,
   input  logic                  timer_irq,
   input  logic                  sw_irq,
   input  logic                  cpu_halt
);

   timeunit 1ns;
   timeprecision 100ps;

   import mmr_map_pkg::*;

   int fail_count = 0;                         // Read by the testbench at the end

   // ----------------------------------------------------------------------
   // Bus rules
   // ----------------------------------------------------------------------
   // Request and payload frozen until the device acknowledges
   a_io_hold : assert property (@(posedge clk_in) disable iff (rst)
      (io_req && !io_ack) |=> (io_req && $stable(io_addr) && $stable(io_wr_data)
                               && $stable(io_rd) && $stable(io_wr)))
   else
   begin
      $error("External request or payload changed before acknowledge");
      fail_count++;
   end

   a_pready_access : assert property (@(posedge clk_in) disable iff (rst)
      pready |-> (psel && penable))            // Only inside an access phase
   else
   begin
      $error("pready high outside an APB access phase");
      fail_count++;
   end

   // ----------------------------------------------------------------------
   // Interrupt rules
   // ----------------------------------------------------------------------
   a_msip_write : assert property (@(posedge clk_in) disable iff (rst)
      (wr_en && (wr_sel == SEL_MSIP)) |=> (sw_irq == $past(wr_data[0])))
   else
   begin
      $error("sw_irq does not match the msip bit just written");
      fail_count++;
   end

   a_msip_hold : assert property (@(posedge clk_in) disable iff (rst)
      !(wr_en && (wr_sel == SEL_MSIP)) |=> $stable(sw_irq))   // No write, no change
   else
   begin
      $error("sw_irq changed without an msip write");
      fail_count++;
   end

   a_wake : assert property (@(posedge clk_in) disable iff (rst)
      (timer_irq || sw_irq || ext_irq) |=> !cpu_halt)
   else
   begin
      $error("cpu_halt high in the cycle after a pending interrupt");
      fail_count++;
   end

endmodule : riscy_irq_checker

`default_nettype wire

// File: dv/riscy_irq_tb.sv
// Testbench for the interrupt and I/O block with APB driver, I/O responder and watchdog
`default_nettype none

module riscy_irq_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import bus_pkg::*;
   import mmr_map_pkg::*;

   localparam int MAX_XFERS       = 60;        // Upper bound on APB transfers in the run
   localparam int XFER_CYCLES     = 8;         // Setup, access, idle and up to 3 I/O waits
   localparam int WATCHDOG_CYCLES = MAX_XFERS * XFER_CYCLES * 10 + 200;

   logic  clk_in;
   logic  rst;
   addr_t paddr;
   logic  psel;
   logic  penable;
   logic  pwrite;
   data_t pwdata;
   data_t prdata;
   logic  pready;
   logic  pslverr;
   logic  io_req;
   addr_t io_addr;
   logic  io_rd;
   logic  io_wr;
   data_t io_wr_data;
   logic  io_ack;
   logic  io_ack_fault;
   data_t io_ack_data;
   logic  ext_irq;
   logic  wfi;
   logic  timer_irq;
   logic  sw_irq;
   logic  cpu_halt;

   integer seed = 65;
   int     errors = 0;
   int     io_req_cycles = 0;                  // Cycles with io_req high
   logic   fault_next;                         // Responder faults the next request
   addr_t  seen_addr;                          // Last request as the responder saw it
   logic   seen_rd;
   logic   seen_wr;
   data_t  seen_wdata;
   data_t  resp_data;
   data_t  io_mem [addr_t];                    // Device memory model

   riscy_irq_top
   #(
      .INT_IO_BASE (INT_IO_BASE),
      .EXT_IO_LO   (EXT_IO_LO),
      .EXT_IO_HI   (EXT_IO_HI)
   )
   i_riscy_irq_top
   (
      .clk_in       (clk_in),
      .rst          (rst),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .io_req       (io_req),
      .io_addr      (io_addr),
      .io_rd        (io_rd),
      .io_wr        (io_wr),
      .io_wr_data   (io_wr_data),
      .io_ack       (io_ack),
      .io_ack_fault (io_ack_fault),
      .io_ack_data  (io_ack_data),
      .ext_irq      (ext_irq),
      .wfi          (wfi),
      .timer_irq    (timer_irq),
      .sw_irq       (sw_irq),
      .cpu_halt     (cpu_halt)
   );

   bind riscy_irq_top riscy_irq_checker i_riscy_irq_checker
   (
      .clk_in     (clk_in),
      .rst        (rst),
      .psel       (psel),
      .penable    (penable),
      .pready     (pready),
      .io_req     (io_req),
      .io_ack     (io_ack),
      .io_addr    (io_addr),
      .io_rd      (io_rd),
      .io_wr      (io_wr),
      .io_wr_data (io_wr_data),
      .wr_en      (wr_en),
      .wr_sel     (wr_sel),
      .wr_data    (wr_data),
      .ext_irq    (ext_irq),
      .timer_irq  (timer_irq),
      .sw_irq     (sw_irq),
      .cpu_halt   (cpu_halt)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #4 clk_in = ~clk_in;             // 8 ns period
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // One APB transfer, setup then access until pready
   task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                               output data_t rdata, output logic err);
      @(negedge clk_in);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk_in);
      penable = 1'b1;
      #2;                                      // Mid cycle, clear of both edges
      while (!pready)
      begin
         @(negedge clk_in);
         #2;
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk_in);                       // Transfer closed at the edge before
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_reg(input addr_t addr, input data_t data);
      data_t rdata;
      logic  err;
      apb_transfer(1'b1, addr, data, rdata, err);
   endtask

   task automatic read_reg(input addr_t addr, output data_t data);
      logic err;
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   // ----------------------------------------------------------------------
   // External device with random latency
   // ----------------------------------------------------------------------
   initial
   begin : responder
      int delay;
      forever
      begin
         @(negedge clk_in);
         if (io_req && !io_ack)
         begin
            delay = {$random(seed)} % 4;       // 0 to 3 wait cycles
            repeat (delay) @(negedge clk_in);
            seen_addr  = io_addr;
            seen_rd    = io_rd;
            seen_wr    = io_wr;
            seen_wdata = io_wr_data;
            if (io_wr && !fault_next)
               io_mem[io_addr] = io_wr_data;
            resp_data    = io_mem.exists(io_addr) ? io_mem[io_addr] : ~io_addr;
            io_ack       = 1'b1;
            io_ack_fault = fault_next;
            io_ack_data  = resp_data;
            @(negedge clk_in);
            io_ack       = 1'b0;
            io_ack_fault = 1'b0;
            io_ack_data  = '0;
         end
      end
   end

   always @(negedge clk_in)
   begin
      if (io_req)
         io_req_cycles++;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_in);
      $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   initial
   begin : stimulus
      data_t rdata;
      data_t first;
      data_t rnd;
      addr_t addr;
      logic  err;
      int    req_before;
      int    total;
      addr_t bad_addr [5];

      rst          = 1'b1;
      paddr        = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      pwdata       = '0;
      io_ack       = 1'b0;
      io_ack_fault = 1'b0;
      io_ack_data  = '0;
      ext_irq      = 1'b0;
      wfi          = 1'b0;
      fault_next   = 1'b0;
      repeat (2) @(negedge clk_in);            // Two reset cycles
      rst = 1'b0;
      check_value("reset outputs", 6'b0, {io_req, pready, pslverr, cpu_halt, sw_irq, timer_irq});

      // Software interrupt
      write_reg(INT_IO_BASE + MSIP_OFS, 32'h1);
      check_value("msip set irq", 1, sw_irq);
      read_reg(INT_IO_BASE + MSIP_OFS, rdata);
      check_value("msip set read", 1, rdata);
      write_reg(INT_IO_BASE + MSIP_OFS, 32'h0);
      check_value("msip clear irq", 0, sw_irq);
      read_reg(INT_IO_BASE + MSIP_OFS, rdata);
      check_value("msip clear read", 0, rdata);

      // mtime counting and high half write
      read_reg(INT_IO_BASE + MTIME_LO_OFS, first);
      read_reg(INT_IO_BASE + MTIME_LO_OFS, rdata);
      check_value("mtime increasing", 1, rdata > first);
      rnd = $random(seed) & 32'h7FFF_FFFF;
      write_reg(INT_IO_BASE + MTIME_LO_OFS, 32'h0);
      write_reg(INT_IO_BASE + MTIME_HI_OFS, rnd);
      read_reg(INT_IO_BASE + MTIME_HI_OFS, rdata);
      check_value("mtime hi write", rnd, rdata);

      // Timer interrupt
      read_reg(INT_IO_BASE + MTIMECMP_LO_OFS, rdata);
      check_value("mtimecmp reset lo", MTIMECMP_RESET[31:0], rdata);
      read_reg(INT_IO_BASE + MTIMECMP_HI_OFS, rdata);
      check_value("mtimecmp reset hi", MTIMECMP_RESET[63:32], rdata);
      check_value("timer idle", 0, timer_irq);
      write_reg(INT_IO_BASE + MTIME_LO_OFS, 32'h0);
      write_reg(INT_IO_BASE + MTIME_HI_OFS, 32'h0);
      write_reg(INT_IO_BASE + MTIMECMP_HI_OFS, 32'h0);
      write_reg(INT_IO_BASE + MTIMECMP_LO_OFS, 32'd40);
      check_value("timer before compare", 0, timer_irq);
      repeat (60) @(negedge clk_in);
      check_value("timer fired", 1, timer_irq);
      write_reg(INT_IO_BASE + MTIMECMP_LO_OFS, 32'hFFFF_FFFF);
      write_reg(INT_IO_BASE + MTIMECMP_HI_OFS, 32'hFFFF_FFFF);
      check_value("timer cleared", 0, timer_irq);

      // External I/O, one write then one read per address
      for (int i = 0; i < 6; i++)
      begin
         addr       = EXT_IO_LO + ({$random(seed)} & 32'h0000_FFFC);
         rnd        = $random(seed);
         fault_next = (i == 4);
         apb_transfer(1'b1, addr, rnd, rdata, err);
         check_value("io write addr", addr, seen_addr);
         check_value("io write data", rnd, seen_wdata);
         check_value("io write dir", 2'b01, {seen_rd, seen_wr});
         check_value("io write err", fault_next, err);
         fault_next = (i == 5);
         apb_transfer(1'b0, addr, '0, rdata, err);
         check_value("io read addr", addr, seen_addr);
         check_value("io read dir", 2'b10, {seen_rd, seen_wr});
         check_value("io read data", resp_data, rdata);
         check_value("io read err", fault_next, err);
      end
      fault_next = 1'b0;

      // Unmapped addresses, a misaligned msip write among them
      bad_addr   = '{32'h0000_1000, INT_IO_BASE + 32'h4, INT_IO_BASE + 32'h18,
                     EXT_IO_HI + 32'h1, INT_IO_BASE + 32'h1};
      req_before = io_req_cycles;
      foreach (bad_addr[i])
      begin
         apb_transfer(1'b0, bad_addr[i], '0, rdata, err);
         check_value("unmapped read err", 1, err);
         check_value("unmapped read data", 0, rdata);
         apb_transfer(1'b1, bad_addr[i], 32'h1, rdata, err);
         check_value("unmapped write err", 1, err);
      end
      check_value("unmapped no side effect", 0, sw_irq);
      check_value("unmapped io_req cycles", req_before, io_req_cycles);

      // Halt and wake
      @(negedge clk_in);
      wfi = 1'b1;
      @(negedge clk_in);
      wfi = 1'b0;
      check_value("halt on wfi", 1, cpu_halt);
      ext_irq = 1'b1;
      @(negedge clk_in);
      ext_irq = 1'b0;
      check_value("wake on ext_irq", 0, cpu_halt);
      write_reg(INT_IO_BASE + MSIP_OFS, 32'h1);
      wfi = 1'b1;
      @(negedge clk_in);
      wfi = 1'b0;
      check_value("wfi with sw_irq", 0, cpu_halt);
      write_reg(INT_IO_BASE + MSIP_OFS, 32'h0);

      repeat (2) @(negedge clk_in);
      total = errors + i_riscy_irq_top.i_riscy_irq_checker.fail_count;
      $display("Errors: %0d data, %0d assertion", errors,
               i_riscy_irq_top.i_riscy_irq_checker.fail_count);
      if (total == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule : riscy_irq_tb

`default_nettype wire

// File: all.f
hw/bus_pkg.sv
hw/mmr_map_pkg.sv
hw/mmr_decoder.sv
hw/interrupt_unit.sv
hw/riscy_irq_top.sv
dv/riscy_irq_checker.sv
dv/riscy_irq_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module riscy_irq_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vriscy_irq_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1
